//--- files.f
+incdir+include
design/rob_pkg.sv
design/alloc_stage.sv
design/alu_unit.sv
design/mul_unit.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/ooo_backend_top.sv
sim/tb_top.sv

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic report_mismatch(input string what);
    stop_run($sformatf("MISMATCH at time %0t: %s", $time, what));
endtask

task automatic check_commit(input commit_t got, input commit_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("commit rd %0d data %h, expected rd %0d data %h",
                                  got.rd, got.data, exp.rd, exp.data));
    end
endtask

task automatic check_redirect(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    if (got !== exp) begin
        report_mismatch($sformatf("redirect pc %h, expected %h", got, exp));
    end
endtask

task automatic check_reg(input logic [reg_w-1:0] idx, input logic [xlen-1:0] got,
                         input logic [xlen-1:0] exp);
    if (got !== exp) begin
        report_mismatch($sformatf("register x%0d reads %h, expected %h", idx, got, exp));
    end
endtask

`endif

//--- sim/tb_top.sv
module tb_top;
    import rob_pkg::*;

    logic             clk;
    logic             reset;
    logic             issue_valid;
    uop_t             issue_uop;
    logic             full;
    logic             commit_valid;
    commit_t          commit;
    logic             flush;
    logic [xlen-1:0]  redirect_pc;
    logic [reg_w-1:0] rd_addr;
    logic [xlen-1:0]  rd_data;

    // reference model state
    commit_t          exp_q[$];
    logic [xlen-1:0]  model_regs [32];
    logic [xlen-1:0]  exp_redirect;
    int               n_issued;
    int               n_flushes;

    `include "tb_checks.svh"

    ooo_backend_top ooo_backend_top_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .full         (full),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // budget grows with every issued op
    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= 200 * n_issued + 1000) begin
            @(posedge clk);
            cycles++;
        end
        stop_run("timeout: the DUT did not retire the issued ops in time");
    end

    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            if (exp_q.size() == 0) begin
                stop_run("a commit appeared with no issued op left to retire");
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && flush) begin
            n_flushes++;
            check_redirect(redirect_pc, exp_redirect);
        end
    end

    function automatic logic is_branch(input op_e op);
        return (op == op_beq) || (op == op_bne);
    endfunction

    function automatic logic [xlen-1:0] expected_result(input uop_t u);
        logic [xlen-1:0] r;
        case (u.op)
            op_add:  r = u.src_a + u.src_b;
            op_sub:  r = u.src_a - u.src_b;
            op_and:  r = u.src_a & u.src_b;
            op_xor:  r = u.src_a ^ u.src_b;
            op_mul:  r = u.src_a * u.src_b;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic uop_t make_uop(input op_e op, input logic [reg_w-1:0] rd,
                                      input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        uop_t u;
        u       = '0;
        u.op    = op;
        u.rd    = rd;
        u.src_a = a;
        u.src_b = b;
        return u;
    endfunction

    // called just after a falling edge, returns one cycle later
    task automatic issue_op(input uop_t u, input logic expected);
        commit_t c;
        issue_valid = 1'b1;
        issue_uop   = u;
        n_issued++;
        if (expected) begin
            if (full) begin
                stop_run("full was high at an issue the buffer had room for");
            end
            c.rd   = is_branch(u.op) ? '0 : u.rd;
            c.data = expected_result(u);
            exp_q.push_back(c);
            if (c.rd != '0) begin
                model_regs[c.rd] = c.data;
            end
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // room for a stray commit to show up
        repeat (8) @(negedge clk);
    endtask

    task automatic verify_reg(input logic [reg_w-1:0] idx);
        rd_addr = idx;
        @(negedge clk);
        check_reg(idx, rd_data, model_regs[idx]);
    endtask

    task automatic single_alu();
        int n;
        issue_op(make_uop(op_add, 5'd3, 32'd1200, 32'd34), 1'b1);
        n = 1;
        while (!commit_valid) begin
            @(negedge clk);
            n++;
        end
        if (n != 3) begin
            stop_run($sformatf("add retired %0d cycles after issue instead of 3", n));
        end
        drain();
        verify_reg(5'd3);
    endtask

    task automatic out_of_order();
        issue_op(make_uop(op_mul, 5'd4, 32'h0001_2345, 32'h0000_6789), 1'b1);
        issue_op(make_uop(op_add, 5'd5, 32'd10, 32'd20), 1'b1);
        issue_op(make_uop(op_sub, 5'd6, 32'd5, 32'd9), 1'b1);
        issue_op(make_uop(op_xor, 5'd7, 32'hf0f0_f0f0, 32'h0ff0_0ff0), 1'b1);
        issue_op(make_uop(op_and, 5'd8, 32'hdead_beef, 32'h00ff_ff00), 1'b1);
        drain();
        for (int r = 4; r <= 8; r++) begin
            verify_reg(reg_w'(r));
        end
    endtask

    task automatic random_mix();
        int   sel;
        uop_t u;
        for (int i = 0; i < 200; i++) begin
            sel = $urandom_range(4);
            u   = make_uop(op_e'(sel), reg_w'($urandom_range(31)), $urandom(), $urandom());
            issue_op(u, 1'b1);
            if ($urandom_range(3) == 0) begin
                @(negedge clk);
            end
        end
        drain();
        // x0 included
        for (int r = 0; r < 32; r++) begin
            verify_reg(reg_w'(r));
        end
    endtask

    // retirement keeps pace with issue, so the buffer never fills
    task automatic full_stream();
        for (int i = 0; i < 17; i++) begin
            issue_op(make_uop(op_mul, reg_w'(i + 14), $urandom(), $urandom()), 1'b1);
        end
        drain();
    endtask

    task automatic mispredict(input logic actual_taken);
        uop_t br;
        int   base;
        br            = make_uop(op_beq, 5'd20, 32'd7, actual_taken ? 32'd7 : 32'd8);
        br.pc         = 32'h0000_1040;
        br.target     = 32'h0000_2400;
        br.pred_taken = !actual_taken;
        exp_redirect  = actual_taken ? br.target : br.pc + 32'd4;
        base          = n_flushes;
        issue_op(br, 1'b1);
        // wrong path, the last one lands in the flush cycle
        issue_op(make_uop(op_mul, 5'd21, 32'd9, 32'd9), 1'b0);
        issue_op(make_uop(op_add, 5'd22, 32'd5, 32'd6), 1'b0);
        issue_op(make_uop(op_xor, 5'd23, 32'hff, 32'h0f), 1'b0);
        // new path right behind the flush reuses the killed tags
        issue_op(make_uop(op_mul, 5'd21, 32'd1234, 32'd5678), 1'b1);
        issue_op(make_uop(op_add, 5'd22, 32'd40, 32'd2), 1'b1);
        drain();
        if (n_flushes - base != 1) begin
            stop_run($sformatf("saw %0d flushes for one mispredicted branch", n_flushes - base));
        end
        for (int r = 20; r <= 23; r++) begin
            verify_reg(reg_w'(r));
        end
    endtask

    task automatic correct_prediction();
        uop_t br;
        int   base;
        br            = make_uop(op_beq, 5'd0, 32'd42, 32'd42);
        br.pc         = 32'h0000_3000;
        br.target     = 32'h0000_3800;
        br.pred_taken = 1'b1;
        base          = n_flushes;
        issue_op(br, 1'b1);
        issue_op(make_uop(op_add, 5'd24, 32'd100, 32'd23), 1'b1);
        issue_op(make_uop(op_mul, 5'd25, 32'd321, 32'd3), 1'b1);
        drain();
        if (n_flushes != base) begin
            stop_run("a correctly predicted branch raised flush");
        end
        verify_reg(5'd24);
        verify_reg(5'd25);
    endtask

    initial begin
        int seed;
        seed = 32'hee33;
        void'($urandom(seed));
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue_uop    = '0;
        rd_addr      = '0;
        exp_redirect = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        single_alu();
        out_of_order();
        random_mix();
        full_stream();
        mispredict(1'b1);
        mispredict(1'b0);
        correct_prediction();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- design/ooo_backend_top.sv
module ooo_backend_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  rob_pkg::uop_t             issue_uop,
    output logic                      full,
    output logic                      commit_valid,
    output rob_pkg::commit_t          commit,
    output logic                      flush,
    output logic [rob_pkg::xlen-1:0]  redirect_pc,
    input  logic [rob_pkg::reg_w-1:0] rd_addr,
    output logic [rob_pkg::xlen-1:0]  rd_data
);
    import rob_pkg::*;

    logic             alloc_valid;
    uop_t             alloc_uop;
    logic [tag_w-1:0] alloc_tag;
    logic             alu_valid;
    exec_t            alu_req;
    logic             mul_valid;
    exec_t            mul_req;
    logic             alu_cpl_valid;
    cpl_t             alu_cpl;
    logic             mul_cpl_valid;
    cpl_t             mul_cpl;

    alloc_stage alloc_stage_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .full        (full),
        .alloc_tag   (alloc_tag),
        .alloc_valid (alloc_valid),
        .alloc_uop   (alloc_uop),
        .alu_valid   (alu_valid),
        .alu_req     (alu_req),
        .mul_valid   (mul_valid),
        .mul_req     (mul_req)
    );

    alu_unit alu_unit_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .alu_valid     (alu_valid),
        .alu_req       (alu_req),
        .alu_cpl_valid (alu_cpl_valid),
        .alu_cpl       (alu_cpl)
    );

    mul_unit mul_unit_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .mul_valid     (mul_valid),
        .mul_req       (mul_req),
        .mul_cpl_valid (mul_cpl_valid),
        .mul_cpl       (mul_cpl)
    );

    reorder_buffer reorder_buffer_i (
        .clk           (clk),
        .reset         (reset),
        .alloc_valid   (alloc_valid),
        .alloc_uop     (alloc_uop),
        .alloc_tag     (alloc_tag),
        .full          (full),
        .alu_cpl_valid (alu_cpl_valid),
        .alu_cpl       (alu_cpl),
        .mul_cpl_valid (mul_cpl_valid),
        .mul_cpl       (mul_cpl),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    arch_regfile arch_regfile_i (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit       (commit),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

//--- design/arch_regfile.sv
module arch_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      commit_valid,
    input  rob_pkg::commit_t          commit,
    input  logic [rob_pkg::reg_w-1:0] rd_addr,
    output logic [rob_pkg::xlen-1:0]  rd_data
);
    import rob_pkg::*;

    logic [xlen-1:0] regs [2**reg_w];

    // x0 is never written, so it reads back zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_w; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && (commit.rd != '0)) begin
            regs[commit.rd] <= commit.data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

//--- design/reorder_buffer.sv
module reorder_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      alloc_valid,
    input  rob_pkg::uop_t             alloc_uop,
    output logic [rob_pkg::tag_w-1:0] alloc_tag,
    output logic                      full,
    input  logic                      alu_cpl_valid,
    input  rob_pkg::cpl_t             alu_cpl,
    input  logic                      mul_cpl_valid,
    input  rob_pkg::cpl_t             mul_cpl,
    output logic                      commit_valid,
    output rob_pkg::commit_t          commit,
    output logic                      flush,
    output logic [rob_pkg::xlen-1:0]  redirect_pc
);
    import rob_pkg::*;

    localparam logic [tag_w:0] depth_c = (tag_w + 1)'(rob_depth);

    rob_entry_t       entries [rob_depth];
    rob_entry_t       head_entry;
    rob_entry_t       new_entry;
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;
    logic [tag_w:0]   occupancy;
    logic             is_branch;

    // an allocation still on its way in already owns the tail slot
    assign occupancy = count + {{tag_w{1'b0}}, alloc_valid};
    assign full      = (occupancy == depth_c);
    assign alloc_tag = tail + {{(tag_w - 1){1'b0}}, alloc_valid};

    assign head_entry   = entries[head];
    assign commit_valid = (count != '0) && head_entry.done;
    assign commit.rd    = head_entry.rd;
    assign commit.data  = head_entry.data;

    // mispredict on retire kills everything younger
    assign flush = commit_valid && head_entry.is_branch
                   && (head_entry.taken != head_entry.pred_taken);
    assign redirect_pc = head_entry.taken ? head_entry.target
                                          : head_entry.pc + 32'd4;

    assign is_branch = (alloc_uop.op == op_beq) || (alloc_uop.op == op_bne);

    always_comb begin
        new_entry            = '0;
        new_entry.rd         = is_branch ? '0 : alloc_uop.rd;
        new_entry.is_branch  = is_branch;
        new_entry.pred_taken = alloc_uop.pred_taken;
        new_entry.pc         = alloc_uop.pc;
        new_entry.target     = alloc_uop.target;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= occupancy - {{tag_w{1'b0}}, commit_valid};
        end
    end

    // both completion ports may land in the same cycle on different tags
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (alloc_valid) begin
                entries[tail] <= new_entry;
            end
            if (alu_cpl_valid) begin
                entries[alu_cpl.tag].done  <= 1'b1;
                entries[alu_cpl.tag].data  <= alu_cpl.data;
                entries[alu_cpl.tag].taken <= alu_cpl.taken;
            end
            if (mul_cpl_valid) begin
                entries[mul_cpl.tag].done  <= 1'b1;
                entries[mul_cpl.tag].data  <= mul_cpl.data;
                entries[mul_cpl.tag].taken <= mul_cpl.taken;
            end
        end
    end

endmodule

//--- design/mul_unit.sv
module mul_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           mul_valid,
    input  rob_pkg::exec_t mul_req,
    output logic           mul_cpl_valid,
    output rob_pkg::cpl_t  mul_cpl
);
    import rob_pkg::*;

    // stage 1 operands
    logic             s1_valid;
    logic [tag_w-1:0] s1_tag;
    logic [xlen-1:0]  s1_a;
    logic [xlen-1:0]  s1_b;

    // stage 2 partial products
    logic             s2_valid;
    logic [tag_w-1:0] s2_tag;
    logic [xlen-1:0]  s2_lo;
    logic [15:0]      s2_hi;

    logic [xlen-1:0]  prod_lo;
    logic [15:0]      prod_hi;

    // only the low 16 bits of the upper product land in the low word
    assign prod_lo = s1_a * s1_b[15:0];
    assign prod_hi = s1_a[15:0] * s1_b[31:16];

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            mul_cpl_valid <= 1'b0;
        end else begin
            s1_valid      <= mul_valid && !flush;
            s2_valid      <= s1_valid && !flush;
            mul_cpl_valid <= s2_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag        <= mul_req.tag;
        s1_a          <= mul_req.uop.src_a;
        s1_b          <= mul_req.uop.src_b;
        s2_tag        <= s1_tag;
        s2_lo         <= prod_lo;
        s2_hi         <= prod_hi;
        mul_cpl.tag   <= s2_tag;
        mul_cpl.data  <= s2_lo + {s2_hi, 16'b0};
        mul_cpl.taken <= 1'b0;
    end

endmodule

//--- design/alu_unit.sv
module alu_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           alu_valid,
    input  rob_pkg::exec_t alu_req,
    output logic           alu_cpl_valid,
    output rob_pkg::cpl_t  alu_cpl
);
    import rob_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] result;
    logic            taken;

    assign src_a = alu_req.uop.src_a;
    assign src_b = alu_req.uop.src_b;

    // branches report through taken, data stays zero
    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (alu_req.uop.op)
            op_add:  result = src_a + src_b;
            op_sub:  result = src_a - src_b;
            op_and:  result = src_a & src_b;
            op_xor:  result = src_a ^ src_b;
            op_beq:  taken  = (src_a == src_b);
            op_bne:  taken  = (src_a != src_b);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_cpl_valid <= 1'b0;
        end else begin
            alu_cpl_valid <= alu_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            alu_cpl.tag   <= alu_req.tag;
            alu_cpl.data  <= result;
            alu_cpl.taken <= taken;
        end
    end

endmodule

//--- design/alloc_stage.sv
module alloc_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      issue_valid,
    input  rob_pkg::uop_t             issue_uop,
    input  logic                      full,
    input  logic [rob_pkg::tag_w-1:0] alloc_tag,
    output logic                      alloc_valid,
    output rob_pkg::uop_t             alloc_uop,
    output logic                      alu_valid,
    output rob_pkg::exec_t            alu_req,
    output logic                      mul_valid,
    output rob_pkg::exec_t            mul_req
);
    import rob_pkg::*;

    logic  accept;
    logic  is_mul;
    exec_t req;

    // issue is dropped while full or while the pipe is being flushed
    assign accept = issue_valid && !full && !flush;
    assign is_mul = (issue_uop.op == op_mul);
    assign req    = '{uop: issue_uop, tag: alloc_tag};

    always_ff @(posedge clk) begin
        if (reset) begin
            alloc_valid <= 1'b0;
            alu_valid   <= 1'b0;
            mul_valid   <= 1'b0;
        end else begin
            alloc_valid <= accept;
            alu_valid   <= accept && !is_mul;
            mul_valid   <= accept && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alloc_uop <= issue_uop;
            if (is_mul) begin
                mul_req <= req;
            end else begin
                alu_req <= req;
            end
        end
    end

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

    localparam int xlen      = 32;
    localparam int rob_depth = 16;
    localparam int tag_w     = 4;
    localparam int reg_w     = 5;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_beq,
        op_bne
    } op_e;

    // micro-op as sent by the front end, operands already read
    typedef struct packed {
        op_e              op;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  src_a;
        logic [xlen-1:0]  src_b;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  target;
        logic             pred_taken;
    } uop_t;

    typedef struct packed {
        uop_t             uop;
        logic [tag_w-1:0] tag;
    } exec_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
        logic             taken;
    } cpl_t;

    typedef struct packed {
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  data;
    } commit_t;

    // one reorder-buffer slot
    typedef struct packed {
        logic             done;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  data;
        logic             is_branch;
        logic             pred_taken;
        logic             taken;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  target;
    } rob_entry_t;

endpackage
